/* decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_pkg::if_id_t          if_id,
  input  rv_pkg::wb_t             wb,        // register write from writeback
  input  logic                    redirect,
  input  logic [4:0]              dbg_addr,
  output rv_pkg::id_ex_t          id_ex,
  output logic                    stall,
  output logic [rv_pkg::xlen-1:0] dbg_data
);

  rv_pkg::inst_t           inst;
  rv_pkg::ctrl_t           ctrl;
  rv_pkg::alu_op_t         alu_op;
  logic [rv_pkg::xlen-1:0] imm;
  logic                    uses_rs1;
  logic                    uses_rs2;
  logic [4:0]              rs1;
  logic [4:0]              rs2;
  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;

  // funct3 map, sub only from an R-type funct7
  function automatic rv_pkg::alu_op_t alu_decode(input logic [2:0] funct3, input logic sub);
    case (funct3)
      3'b000:  return sub ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b010:  return rv_pkg::alu_slt;
      3'b100:  return rv_pkg::alu_xor;
      3'b110:  return rv_pkg::alu_or;
      3'b111:  return rv_pkg::alu_and;
      default: return rv_pkg::alu_add;
    endcase
  endfunction

  assign inst = if_id.inst;

  always_comb begin
    ctrl     = '0;
    alu_op   = rv_pkg::alu_add;  // address add for lw and sw
    imm      = '0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (inst.r_fmt.opcode)
      rv_pkg::op_r: begin
        ctrl.reg_write = 1'b1;
        alu_op   = alu_decode(inst.r_fmt.funct3, inst.r_fmt.funct7[5]);
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      rv_pkg::op_i: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        alu_op   = alu_decode(inst.i_fmt.funct3, 1'b0);  // no subi
        imm      = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        uses_rs1 = 1'b1;
      end
      rv_pkg::op_load: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_src   = 1'b1;
        imm      = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        uses_rs1 = 1'b1;
      end
      rv_pkg::op_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        imm      = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;  // store data
      end
      rv_pkg::op_branch: begin
        ctrl.is_branch = 1'b1;
        ctrl.branch_ne = inst.b_fmt.funct3[0];  // 000 beq, 001 bne
        alu_op   = rv_pkg::alu_sub;
        imm      = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      rv_pkg::op_system: begin
        ctrl.is_ecall = 1'b1;
        uses_rs1 = 1'b1;  // reads x17
      end
      default: ;  // unsupported, decodes as a bubble
    endcase
  end

  assign rs1 = ctrl.is_ecall ? 5'd17 : inst.r_fmt.rs1;
  assign rs2 = inst.r_fmt.rs2;

  // load in execute feeding a source used here
  assign stall = if_id.valid && id_ex.ctrl.mem_read && id_ex.rd != 5'd0 &&
                 ((uses_rs1 && rs1 == id_ex.rd) || (uses_rs2 && rs2 == id_ex.rd));

  register_file u_register_file (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .wb       (wb),
    .dbg_addr (dbg_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dbg_data (dbg_data)
  );

  always_ff @(posedge clk) begin
    id_ex.alu_op   <= alu_op;
    id_ex.pc       <= if_id.pc;
    id_ex.rs1_data <= rs1_data;
    id_ex.rs2_data <= rs2_data;
    id_ex.imm      <= imm;
    id_ex.rs1      <= rs1;
    id_ex.rs2      <= rs2;
    id_ex.rd       <= inst.r_fmt.rd;
    if (reset || stall || redirect || !if_id.valid) begin
      id_ex.ctrl <= '0;  // bubble
    end else begin
      id_ex.ctrl <= ctrl;
    end
  end

endmodule

/* execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_pkg::id_ex_t          id_ex,
  input  rv_pkg::wb_t             wb,           // older result, second forward source
  output rv_pkg::ex_mem_t         ex_mem,
  output logic                    redirect,
  output logic [rv_pkg::xlen-1:0] redirect_pc
);

  logic [rv_pkg::xlen-1:0] op_a;      // forwarded rs1
  logic [rv_pkg::xlen-1:0] rs2_fwd;   // forwarded rs2, also store data
  logic [rv_pkg::xlen-1:0] op_b;
  logic [rv_pkg::xlen-1:0] alu_out;
  logic                    taken;
  logic                    halt;

  // newest match wins; a load never sits in ex_mem with a dependent here
  always_comb begin
    if (id_ex.rs1 != 5'd0 && ex_mem.ctrl.reg_write && ex_mem.rd == id_ex.rs1) begin
      op_a = ex_mem.alu_out;
    end else if (id_ex.rs1 != 5'd0 && wb.we && wb.rd == id_ex.rs1) begin
      op_a = wb.data;
    end else begin
      op_a = id_ex.rs1_data;
    end
    if (id_ex.rs2 != 5'd0 && ex_mem.ctrl.reg_write && ex_mem.rd == id_ex.rs2) begin
      rs2_fwd = ex_mem.alu_out;
    end else if (id_ex.rs2 != 5'd0 && wb.we && wb.rd == id_ex.rs2) begin
      rs2_fwd = wb.data;
    end else begin
      rs2_fwd = id_ex.rs2_data;
    end
  end

  assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : rs2_fwd;

  always_comb begin
    case (id_ex.alu_op)
      rv_pkg::alu_add: alu_out = op_a + op_b;
      rv_pkg::alu_sub: alu_out = op_a - op_b;
      rv_pkg::alu_and: alu_out = op_a & op_b;
      rv_pkg::alu_or:  alu_out = op_a | op_b;
      rv_pkg::alu_xor: alu_out = op_a ^ op_b;
      rv_pkg::alu_slt: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      default:         alu_out = op_a + op_b;
    endcase
  end

  // beq on equal, bne on not equal
  assign taken       = id_ex.ctrl.is_branch && ((op_a == rs2_fwd) ^ id_ex.ctrl.branch_ne);
  assign redirect    = taken;
  assign redirect_pc = id_ex.pc + id_ex.imm;

  assign halt = id_ex.ctrl.is_ecall && op_a == 32'd10;  // x17 == 10

  always_ff @(posedge clk) begin
    ex_mem.alu_out    <= alu_out;
    ex_mem.store_data <= rs2_fwd;
    ex_mem.rd         <= id_ex.rd;
    if (reset) begin
      ex_mem.ctrl <= '0;
      ex_mem.halt <= 1'b0;
    end else begin
      ex_mem.ctrl <= id_ex.ctrl;
      ex_mem.halt <= halt;
    end
  end

endmodule

/* fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall,        // load-use hold
  input  logic                    redirect,     // taken branch in execute
  input  logic [rv_pkg::xlen-1:0] redirect_pc,
  input  rv_pkg::inst_t           inst,         // word at pc
  output logic [rv_pkg::xlen-1:0] pc,
  output rv_pkg::if_id_t          if_id
);

  always_ff @(posedge clk) begin
    // payload, held on stall
    if (!stall) begin
      if_id.pc   <= pc;
      if_id.inst <= inst;
    end
    if (reset) begin
      pc          <= '0;    // first fetch at 0
      if_id.valid <= 1'b0;
    end else if (redirect) begin
      // redirect beats stall
      pc          <= redirect_pc;
      if_id.valid <= 1'b0;  // squash the word fetched behind the branch
    end else if (!stall) begin
      pc          <= pc + 4;
      if_id.valid <= 1'b1;
    end
  end

endmodule

/* inst_memory.sv */
`timescale 1ns/100ps

module inst_memory #(
  parameter int IMEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          load_en,    // program load, while reset held
  input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,  // word index
  input  logic [rv_pkg::xlen-1:0]       load_data,
  input  logic [rv_pkg::xlen-1:0]       addr,       // byte address from fetch
  output rv_pkg::inst_t                 inst
);

  localparam int aw = $clog2(IMEM_WORDS);

  rv_pkg::inst_t mem [IMEM_WORDS];  // no reset, loaded by testbench

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // async read, byte offset dropped, wraps at depth
  assign inst = mem[addr[aw+1:2]];

endmodule

/* pipeline_cpu.sv */
`timescale 1ns/100ps

module pipeline_cpu #(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          load_en,    // program write, during reset
  input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,  // word index
  input  logic [rv_pkg::xlen-1:0]       load_data,
  input  logic [4:0]                    dbg_addr,
  output logic [rv_pkg::xlen-1:0]       dbg_data,
  output logic                          halted
);

  logic [rv_pkg::xlen-1:0] pc;
  rv_pkg::inst_t           inst;
  rv_pkg::if_id_t          if_id;
  rv_pkg::id_ex_t          id_ex;
  rv_pkg::ex_mem_t         ex_mem;
  rv_pkg::wb_t             wb;
  logic                    stall;        // from decode only
  logic                    redirect;     // from execute only
  logic [rv_pkg::xlen-1:0] redirect_pc;

  inst_memory #(
    .IMEM_WORDS (IMEM_WORDS)
  ) u_inst_memory (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .addr      (pc),
    .inst      (inst)
  );

  fetch_stage u_fetch_stage (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .inst        (inst),
    .pc          (pc),
    .if_id       (if_id)
  );

  decode_stage u_decode_stage (
    .clk      (clk),
    .reset    (reset),
    .if_id    (if_id),
    .wb       (wb),
    .redirect (redirect),
    .dbg_addr (dbg_addr),
    .id_ex    (id_ex),
    .stall    (stall),
    .dbg_data (dbg_data)
  );

  execute_stage u_execute_stage (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .wb          (wb),
    .ex_mem      (ex_mem),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  result_stage #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_result_stage (
    .clk    (clk),
    .reset  (reset),
    .ex_mem (ex_mem),
    .wb     (wb),
    .halted (halted)
  );

endmodule

/* pipeline_cpu_asserts.sv */
`timescale 1ns/100ps

module pipeline_cpu_asserts (
  input logic           clk,
  input logic           reset,
  input logic           halted,
  input logic           stall,
  input logic           redirect,
  input rv_pkg::if_id_t if_id,
  input rv_pkg::id_ex_t id_ex
);

  int errors = 0;  // failed assertion count

  // only reset clears the end flag
  halted_sticky: assert property (@(posedge clk) !$past(reset) && $past(halted) |-> halted)
    else begin
      errors++;
      $error("halted fell without reset");
    end

  // pipeline registers already cleared from the second reset edge on
  quiet_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !stall && !redirect)
    else begin
      errors++;
      $error("stall or redirect high during reset");
    end

  // both younger slots squashed behind a taken branch
  redirect_squash: assert property (@(posedge clk)
                                    redirect |=> !if_id.valid && id_ex.ctrl == '0)
    else begin
      errors++;
      $error("fetch or decode slot not squashed after a redirect");
    end

endmodule

bind pipeline_cpu pipeline_cpu_asserts u_asserts (
  .clk      (clk),
  .reset    (reset),
  .halted   (halted),
  .stall    (stall),
  .redirect (redirect),
  .if_id    (if_id),
  .id_ex    (id_ex)
);

/* register_file.sv */
`timescale 1ns/100ps

module register_file (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [4:0]              rs1,
  input  logic [4:0]              rs2,
  input  rv_pkg::wb_t             wb,
  input  logic [4:0]              dbg_addr,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data,
  output logic [rv_pkg::xlen-1:0] dbg_data
);

  logic [rv_pkg::xlen-1:0] regs [1:31];  // x0 not stored

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // same-cycle write shows through on the decode ports
  assign rs1_data = (rs1 == 5'd0) ? '0 : (wb.we && wb.rd == rs1) ? wb.data : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : (wb.we && wb.rd == rs2) ? wb.data : regs[rs2];
  assign dbg_data = (dbg_addr == 5'd0) ? '0 : regs[dbg_addr];  // committed state only

endmodule

/* result_stage.sv */
`timescale 1ns/100ps

module result_stage #(
  parameter int DMEM_WORDS = 64
) (
  input  logic            clk,
  input  logic            reset,
  input  rv_pkg::ex_mem_t ex_mem,
  output rv_pkg::wb_t     wb,
  output logic            halted   // sticky until reset
);

  localparam int aw = $clog2(DMEM_WORDS);

  typedef struct packed {
    logic                    reg_write;
    logic                    mem_read;   // picks load data at writeback
    logic                    halt;
    logic [4:0]              rd;
    logic [rv_pkg::xlen-1:0] alu_out;
    logic [rv_pkg::xlen-1:0] load_data;
  } mem_wb_t;

  logic [rv_pkg::xlen-1:0] dmem [DMEM_WORDS];
  logic [aw-1:0]           dm_idx;     // word index, wraps at depth
  logic [rv_pkg::xlen-1:0] load_data;
  mem_wb_t                 mem_wb;
  logic                    halted_q;

  assign dm_idx    = ex_mem.alu_out[aw+1:2];
  assign load_data = dmem[dm_idx];   // async read

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (ex_mem.ctrl.mem_write) begin
      dmem[dm_idx] <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clk) begin
    mem_wb.rd        <= ex_mem.rd;
    mem_wb.alu_out   <= ex_mem.alu_out;
    mem_wb.load_data <= load_data;
    if (reset) begin
      mem_wb.reg_write <= 1'b0;
      mem_wb.mem_read  <= 1'b0;
      mem_wb.halt      <= 1'b0;
      halted_q         <= 1'b0;
    end else begin
      mem_wb.reg_write <= ex_mem.ctrl.reg_write;
      mem_wb.mem_read  <= ex_mem.ctrl.mem_read;
      mem_wb.halt      <= ex_mem.halt;
      halted_q         <= halted_q | mem_wb.halt;  // hold once seen
    end
  end

  // writeback select
  assign wb.we   = mem_wb.reg_write;
  assign wb.rd   = mem_wb.rd;
  assign wb.data = mem_wb.mem_read ? mem_wb.load_data : mem_wb.alu_out;

  // high from the edge the ecall enters writeback
  assign halted = halted_q | mem_wb.halt;

endmodule

/* rv_pkg.sv */
package rv_pkg;

  parameter int xlen = 32;  // data and address width

  // major opcodes of the supported subset
  localparam logic [6:0] op_r      = 7'b0110011;  // add sub and or xor slt
  localparam logic [6:0] op_i      = 7'b0010011;  // addi andi ori
  localparam logic [6:0] op_load   = 7'b0000011;  // lw
  localparam logic [6:0] op_store  = 7'b0100011;  // sw
  localparam logic [6:0] op_branch = 7'b1100011;  // beq bne
  localparam logic [6:0] op_system = 7'b1110011;  // ecall

  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_or  = 4'd3,
    alu_xor = 4'd4,
    alu_slt = 4'd5
  } alu_op_t;

  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;  // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;  // imm[4:0]
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  // one 32-bit word, four views of it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
  } inst_t;

  typedef struct packed {
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic alu_src;    // operand b from imm
    logic is_branch;
    logic branch_ne;  // bne when set, beq otherwise
    logic is_ecall;
  } ctrl_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    inst_t           inst;
  } if_id_t;

  typedef struct packed {
    ctrl_t           ctrl;
    alu_op_t         alu_op;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] imm;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
  } id_ex_t;

  typedef struct packed {
    ctrl_t           ctrl;
    logic [xlen-1:0] alu_out;     // result or memory address
    logic [xlen-1:0] store_data;
    logic [4:0]      rd;
    logic            halt;        // halting ecall
  } ex_mem_t;

  typedef struct packed {
    logic            we;
    logic [4:0]      rd;
    logic [xlen-1:0] data;
  } wb_t;

endpackage

/* sources.f */
rv_pkg.sv
inst_memory.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
pipeline_cpu.sv
pipeline_cpu_asserts.sv
tb_pipeline_cpu.sv

/* tb_pipeline_cpu.sv */
`timescale 1ns/100ps

module tb_pipeline_cpu;

  localparam int imem_words = 128;  // leaves ecall padding past the halt
  localparam int dmem_words = 64;
  localparam logic [31:0] ecall_word = 32'h0000_0073;
  localparam logic [6:0]  op_imm     = 7'h13;
  localparam logic [6:0]  op_lw      = 7'h03;

  logic        clk;
  logic        reset;
  logic        load_en;
  logic [6:0]  load_addr;
  logic [31:0] load_data;
  logic [4:0]  dbg_addr;
  logic [31:0] dbg_data;
  logic        halted;

  logic [31:0] prog [imem_words];
  logic [31:0] m_regs [32];          // reference register file
  logic [31:0] m_mem [dmem_words];   // reference data memory
  logic [31:0] rng = 32'h900d409e;
  int          n;                    // next free program slot
  int          tests = 0;
  int          failed_tests = 0;
  int          errors;               // mismatches in the current test

  pipeline_cpu #(
    .IMEM_WORDS (imem_words),
    .DMEM_WORDS (dmem_words)
  ) uut (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .dbg_addr  (dbg_addr),
    .dbg_data  (dbg_data),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function int rand_below(input int lim);
    rng = xorshift(rng);
    return rng % lim;
  endfunction

  function int pick_reg();
    return 1 + rand_below(8);  // x1..x8 only to keep deps dense
  endfunction

  // rv32i encodings
  function automatic logic [31:0] r_type(input logic [2:0] f3, input logic sub,
                                         input int rd, input int rs1, input int rs2);
    return {1'b0, sub, 5'd0, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input int rd, input int rs1, input logic [11:0] imm);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] sw_word(input int rs1, input int rs2,
                                          input logic [11:0] imm);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] br_word(input logic ne, input int rs1, input int rs2,
                                          input logic [12:0] off);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), 2'b00, ne, off[4:1], off[11], 7'h63};
  endfunction

  function logic [31:0] random_alu();
    int sel;
    sel = rand_below(8);
    case (sel)
      0: return r_type(3'b000, rand_below(2) == 1, pick_reg(), pick_reg(), pick_reg());
      1: return r_type(3'b010, 1'b0, pick_reg(), pick_reg(), pick_reg());  // slt
      2: return r_type(3'b100, 1'b0, pick_reg(), pick_reg(), pick_reg());
      3: return r_type(3'b110, 1'b0, pick_reg(), pick_reg(), pick_reg());
      4: return r_type(3'b111, 1'b0, pick_reg(), pick_reg(), pick_reg());
      5: return i_type(op_imm, 3'b000, pick_reg(), pick_reg(), 12'(rand_below(4096)));
      6: return i_type(op_imm, 3'b110, pick_reg(), pick_reg(), 12'(rand_below(4096)));
      default: return i_type(op_imm, 3'b111, pick_reg(), pick_reg(), 12'(rand_below(4096)));
    endcase
  endfunction

  task emit(input logic [31:0] w);
    prog[n] = w;
    n++;
  endtask

  // kind 0 alu, 1 load/store, 2 branch, 3 non-halting ecalls
  task gen_program(input int kind);
    int len;
    int k;
    int rd;
    for (int i = 0; i < imem_words; i++) begin
      prog[i] = ecall_word;  // padding everywhere
    end
    n = 0;
    len = 24 + rand_below(10);
    while (n < len) begin
      k = rand_below(10);
      if (kind == 1 && k < 3) begin
        emit(sw_word(0, pick_reg(), 12'(4 * rand_below(16))));
      end else if (kind == 1 && k < 6) begin
        rd = pick_reg();
        emit(i_type(op_lw, 3'b010, rd, 0, 12'(4 * rand_below(16))));
        emit(r_type(3'b000, 1'b0, pick_reg(), rd, pick_reg()));  // use right behind it
      end else if (kind == 2 && k < 3) begin
        emit(br_word(rand_below(2) == 1, pick_reg(), pick_reg(), 13'(4 + 4 * rand_below(3))));
      end else if (kind == 3 && k < 2) begin
        emit(i_type(op_imm, 3'b000, 17, 0, 12'(rand_below(10))));  // x17 below 10
        emit(ecall_word);
      end else begin
        emit(random_alu());
      end
    end
    repeat (3) emit(i_type(op_imm, 3'b000, 17, 0, 12'd10));  // branch may land on any copy
  endtask

  // instruction-set model that runs to the halting ecall
  task run_model();
    logic [31:0] w;
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic        wr;
    for (int r = 0; r < 32; r++) begin
      m_regs[r] = '0;
    end
    for (int i = 0; i < dmem_words; i++) begin
      m_mem[i] = '0;
    end
    pc = '0;
    for (int step = 0; step < 1000; step++) begin
      w = prog[(pc >> 2) % imem_words];
      a = m_regs[w[19:15]];
      b = m_regs[w[24:20]];
      imm = {{20{w[31]}}, w[31:20]};
      res = '0;
      wr = 1'b0;
      pc_next = pc + 4;
      case (w[6:0])
        7'h33: begin
          wr = 1'b1;
          case (w[14:12])
            3'd0: res = w[30] ? a - b : a + b;
            3'd2: res = {31'd0, $signed(a) < $signed(b)};
            3'd4: res = a ^ b;
            3'd6: res = a | b;
            default: res = a & b;
          endcase
        end
        7'h13: begin
          wr = 1'b1;
          res = (w[14:12] == 3'd0) ? a + imm : (w[14:12] == 3'd6) ? a | imm : a & imm;
        end
        7'h03: begin
          wr = 1'b1;
          res = m_mem[((a + imm) >> 2) % dmem_words];
        end
        7'h23: m_mem[((a + {{20{w[31]}}, w[31:25], w[11:7]}) >> 2) % dmem_words] = b;
        7'h63: begin
          if ((a == b) != w[12]) begin
            pc_next = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        default: begin
          if (m_regs[17] == 32'd10) return;  // halting ecall
        end
      endcase
      if (wr && w[11:7] != 5'd0) m_regs[w[11:7]] = res;
      pc = pc_next;
    end
  endtask

  // program goes in while reset is held
  task load_program();
    @(negedge clk);
    reset = 1'b1;
    for (int i = 0; i < imem_words; i++) begin
      load_en   = 1'b1;
      load_addr = 7'(i);
      load_data = prog[i];
      @(negedge clk);
    end
    load_en = 1'b0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
  endtask

  task check_regs(input string name);
    for (int r = 1; r < 32; r++) begin
      @(negedge clk);
      dbg_addr = 5'(r);
      #1;  // mid low phase
      if (dbg_data !== m_regs[r]) begin
        $display("[FAIL] %s x%0d expected 0x%08h actual 0x%08h", name, r, m_regs[r],
                 dbg_data);
        errors++;
      end
    end
  endtask

  task report(input string name);
    tests++;
    if (errors == 0) begin
      $display("[PASS] %s", name);
    end else begin
      failed_tests++;
      $display("[DONE] %s with %0d errors", name, errors);
    end
  endtask

  task run_test(input string name, input int kind);
    int cycles;
    errors = 0;
    gen_program(kind);
    run_model();
    load_program();
    dbg_addr = 5'd17;  // x17 seen by the ecall that halts
    cycles = 0;
    while (!halted && cycles < 1000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("%s: halted never rose within %0d cycles", name, cycles);
      errors++;
    end else begin
      if (dbg_data !== m_regs[17]) begin
        $display("[FAIL] %s x17 at halt expected 0x%08h actual 0x%08h", name,
                 m_regs[17], dbg_data);
        errors++;
      end
      check_regs(name);
    end
    report(name);
  endtask

  // all ecalls with x17 at zero so nothing retires a write
  task check_reset_state();
    errors = 0;
    for (int i = 0; i < imem_words; i++) begin
      prog[i] = ecall_word;
    end
    for (int r = 0; r < 32; r++) begin
      m_regs[r] = '0;
    end
    load_program();
    if (halted !== 1'b0) begin
      $display("[FAIL] reset_state halted expected 0 actual %b", halted);
      errors++;
    end
    check_regs("reset_state");
    report("reset_state");
  endtask

  initial begin
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    dbg_addr  = '0;
    repeat (10) @(negedge clk);
    for (int t = 0; t < 3; t++) run_test($sformatf("alu_%0d", t), 0);
    check_reset_state();  // registers dirty from the alu runs
    for (int t = 0; t < 3; t++) run_test($sformatf("mem_%0d", t), 1);
    for (int t = 0; t < 3; t++) run_test($sformatf("branch_%0d", t), 2);
    for (int t = 0; t < 2; t++) run_test($sformatf("ecall_%0d", t), 3);
    $display("tests %0d failed %0d assertion errors %0d", tests, failed_tests,
             uut.u_asserts.errors);
    if (failed_tests == 0 && uut.u_asserts.errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
